//--- compile.f
hdl/vid_pkg.sv
hdl/video_timing.sv
hdl/wb_reg_fsm.sv
hdl/playfield_lut.sv
hdl/video_blend.sv
hdl/video_top.sv
test/tb_video_top.sv

//--- Bender.yml
package:
  name: video_blend_stage

sources:
  - hdl/vid_pkg.sv
  - hdl/video_timing.sv
  - hdl/wb_reg_fsm.sv
  - hdl/playfield_lut.sv
  - hdl/video_blend.sv
  - hdl/video_top.sv
  - target: test
    files:
      - test/tb_video_top.sv

//--- test/tb_video_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video top testbench
// directed bus, geometry and pixel checks
// against a shadow of palettes and control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_video_top;

    localparam int TMO   = 1000;                                 // cycles per bounded wait
    localparam int FRAME = vid_pkg::H_TOTAL * vid_pkg::V_TOTAL;
    localparam int NPIX  = vid_pkg::H_ACTIVE * vid_pkg::V_ACTIVE;
    localparam logic [15:0] CTRL_BITS = 16'h0FF1;                // blend, scroll A, scroll B

    logic             clk;
    logic             rst_n_i;
    logic             wb_cyc_i;
    logic             wb_stb_i;
    logic             wb_we_i;
    vid_pkg::wb_adr_t wb_adr_i;
    vid_pkg::wb_dat_t wb_dat_i;
    vid_pkg::wb_dat_t wb_dat_o;
    logic             wb_ack_o;
    vid_pkg::rgb_t    rgb_o;
    logic             hsync_o;
    logic             vsync_o;
    logic             de_o;

    logic [15:0]      pal_a [16];       // shadow of palette A
    logic [15:0]      pal_b [16];       // shadow of palette B
    logic [15:0]      ctrl_shadow;
    logic             check_en;         // pixel compare on
    int               px;               // tracked raster position
    int               py;
    int               pix_cnt;          // active pixels compared
    logic             vs_prev;
    int unsigned      seed;

    video_top u_video_top (.*);

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] time %0t %s: got %0h, expected %0h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic in_time(input logic ok, input string what);
        assert (ok) else begin
            $display("timeout waiting for %s", what);
            $display("TEST FAILED");
            $fatal(1, "stopping on timeout");
        end
    endtask

    // one channel by the alpha rules
    function automatic int blend_channel(input int a, input int b, input int al_a,
                                         input int al_b);
        case (al_a)
            0: case (al_b)
                   0:       return a;
                   1:       return (3 * a + b) / 4;     // truncated
                   2:       return (a + b) / 2;
                   default: return b;
               endcase
            1:       return (a + b) % 16;               // wraps
            2:       return (a >= 8 && b >= 8) ? 15 : (a + b) % 16;
            default: return a;
        endcase
    endfunction

    function automatic logic [11:0] expected_rgb(input int x, input int y);
        logic [15:0] ca;
        logic [15:0] cb;
        logic [11:0] res;
        ca = pal_a[4'(x + ctrl_shadow[7:4])];   // A runs along the line
        cb = pal_b[4'(y + ctrl_shadow[11:8])];  // B runs down the frame
        if (ctrl_shadow[0]) begin
            for (int c = 0; c < 3; c++) begin
                res[c*4 +: 4] = 4'(blend_channel(ca[c*4 +: 4], cb[c*4 +: 4],
                                                 ca[15:14], cb[15:14]));
            end
        end else begin
            res = (!ca[15] && cb[15]) ? cb[11:0] : ca[11:0];
        end
        return res;
    endfunction

    function automatic logic [3:0] extreme(input int i);
        case (i % 3)
            0:       return 4'h0;
            1:       return 4'h8;
            default: return 4'hF;
        endcase
    endfunction

    // position from the outputs, frame restarts on vsync rise
    always @(negedge clk) begin
        if (!rst_n_i) begin
            px = 0;
            py = 0;
            vs_prev = 1'b0;
        end else begin
            if (vsync_o && !vs_prev) begin
                px = 0;
                py = 0;
            end
            vs_prev = vsync_o;
            if (check_en) begin
                check_value("rgb_o", rgb_o, de_o ? expected_rgb(px, py) : 12'h000);
                pix_cnt += de_o;
            end
            if (de_o) begin
                px++;
                if (px == vid_pkg::H_ACTIVE) begin
                    px = 0;
                    py++;
                end
            end
        end
    end

    task automatic bus_cycle(input logic we, input vid_pkg::wb_adr_t adr,
                             input vid_pkg::wb_dat_t wdat, output vid_pkg::wb_dat_t rdat);
        int cnt;
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        cnt = 0;
        do begin
            @(posedge clk);
            #1;
            cnt++;
        end while (!wb_ack_o && cnt < TMO);
        in_time(wb_ack_o, "wb_ack_o");
        check_value("wb_ack_o latency", cnt, 1);
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(posedge clk);
        #1;
        check_value("wb_ack_o", wb_ack_o, 1'b0);  // single pulse
    endtask

    task automatic wb_write(input vid_pkg::wb_adr_t adr, input vid_pkg::wb_dat_t dat);
        vid_pkg::wb_dat_t unused;
        bus_cycle(1'b1, adr, dat, unused);
        if (adr < vid_pkg::ADR_PAL_B_BASE) pal_a[adr[3:0]] = dat;
        else if (adr < vid_pkg::ADR_CTRL) pal_b[adr[3:0]] = dat;
        else if (adr == vid_pkg::ADR_CTRL) ctrl_shadow = dat & CTRL_BITS;
    endtask

    task automatic wb_read(input vid_pkg::wb_adr_t adr, output vid_pkg::wb_dat_t dat);
        bus_cycle(1'b0, adr, 16'h0000, dat);
    endtask

    task automatic wait_vsync_rise();
        int   cnt;
        logic prev;
        logic seen;
        prev = 1'b1;                    // a vsync already high does not count
        seen = 1'b0;
        cnt  = 0;
        while (!seen && cnt < 2 * FRAME) begin
            @(negedge clk);
            cnt++;
            seen = vsync_o && !prev;
            prev = vsync_o;
        end
        in_time(seen, "rising edge of vsync_o");
    endtask

    // compares one whole frame, vsync rise to vsync rise
    task automatic check_frame();
        wait_vsync_rise();
        pix_cnt  = 0;
        check_en = 1'b1;
        wait_vsync_rise();
        check_en = 1'b0;
        check_value("active pixels per frame", pix_cnt, NPIX);
    endtask

    // mode 0 random, 1 alpha mixes, 2 additive with extreme channels
    task automatic load_palettes(input int mode);
        logic [15:0] ca;
        logic [15:0] cb;
        for (int i = 0; i < 16; i++) begin
            ca = 16'($urandom);
            cb = 16'($urandom);
            if (mode == 1) begin
                ca[15:14] = 2'd0;
                cb[15:14] = 2'(i % 4);  // B lines walk through all four mixes
            end else if (mode == 2) begin
                ca = {2'(1 + i % 3), 2'b00, extreme(i), extreme(i / 3), ca[3:0]};
                cb = {cb[15:12], extreme(i), extreme(i + 1), cb[3:0]};
            end
            wb_write(6'(vid_pkg::ADR_PAL_A_BASE + i), ca);
            wb_write(6'(vid_pkg::ADR_PAL_B_BASE + i), cb);
        end
    endtask

    task automatic check_reset_state();
        check_value("wb_ack_o", wb_ack_o, 1'b0);
        check_value("de_o", de_o, 1'b0);
        check_value("hsync_o", hsync_o, 1'b0);
        check_value("vsync_o", vsync_o, 1'b0);
        check_value("rgb_o", rgb_o, 12'h000);
    endtask

    task automatic check_geometry();
        int   cnt;
        int   run;
        int   period;
        int   lines;
        int   hs_run;
        int   hs_lines;
        logic de_prev;
        logic hs_prev;
        wait_vsync_rise();
        run = 0;
        cnt = 0;
        while (vsync_o && cnt < TMO) begin
            run++;
            @(negedge clk);
            cnt++;
        end
        check_value("vsync_o width", run, vid_pkg::H_TOTAL);
        lines    = 0;
        run      = 0;
        period   = 0;
        hs_run   = 0;
        hs_lines = 0;
        de_prev  = 1'b0;
        hs_prev  = 1'b0;
        cnt      = 0;
        while (!vsync_o && cnt < FRAME) begin
            @(negedge clk);
            cnt++;
            period++;
            if (de_o && !de_prev) begin
                if (lines > 0) check_value("de_o line period", period, vid_pkg::H_TOTAL);
                lines++;
                period = 0;
                run    = 0;
            end
            if (!de_o && de_prev) check_value("de_o pixels per line", run, vid_pkg::H_ACTIVE);
            run += de_o;
            de_prev = de_o;
            if (hsync_o && !hs_prev) begin
                // on an active line the pulse follows the front porch
                if (lines > 0 && period < vid_pkg::H_TOTAL) begin
                    check_value("hsync_o start", period,
                                vid_pkg::H_ACTIVE + vid_pkg::H_FRONT);
                end
                hs_lines++;
                hs_run = 0;
            end
            if (!hsync_o && hs_prev) check_value("hsync_o width", hs_run, vid_pkg::H_SYNC);
            hs_run += hsync_o;
            hs_prev = hsync_o;
        end
        in_time(vsync_o, "next vsync_o");
        check_value("active lines per frame", lines, vid_pkg::V_ACTIVE);
        check_value("hsync_o pulses", hs_lines, vid_pkg::V_TOTAL - vid_pkg::V_SYNC);
    endtask

    task automatic check_bus_access();
        vid_pkg::wb_dat_t rd;
        wb_read(vid_pkg::ADR_CTRL, rd);
        check_value("ctrl after reset", rd, 16'h0000);
        wb_write(vid_pkg::ADR_CTRL, 16'hFFFF);
        wb_read(vid_pkg::ADR_CTRL, rd);
        check_value("ctrl readback", rd, CTRL_BITS);
        wb_write(vid_pkg::ADR_CTRL, 16'hA5A5);
        wb_write(6'h3F, 16'h0000);      // unmapped, must leave ctrl alone
        wb_read(vid_pkg::ADR_CTRL, rd);
        check_value("ctrl readback", rd, 16'hA5A5 & CTRL_BITS);
        wb_read(6'h30, rd);
        check_value("unmapped read", rd, 16'h0000);
        wb_read(6'h05, rd);             // palettes are write only
        check_value("palette read", rd, 16'h0000);
    endtask

    task automatic check_priority_mode();
        load_palettes(0);
        wb_write(vid_pkg::ADR_CTRL, 16'h0000);
        check_frame();
    endtask

    task automatic check_alpha_mix();
        load_palettes(1);
        wb_write(vid_pkg::ADR_CTRL, 16'h0001);
        check_frame();
    endtask

    task automatic check_additive();
        load_palettes(2);
        wb_write(vid_pkg::ADR_CTRL, 16'h0001);
        check_frame();
    endtask

    task automatic check_scroll();
        load_palettes(0);
        wb_write(vid_pkg::ADR_CTRL, 16'h0531);  // B by 5, A by 3, blended
        check_frame();
        wb_write(vid_pkg::ADR_CTRL, 16'h09C0);  // B by 9, A by 12, priority
        check_frame();
    endtask

    initial begin
        seed     = 32'h2a77;
        void'($urandom(seed));
        clk      = 1'b0;
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        check_en = 1'b0;
        pix_cnt  = 0;
        ctrl_shadow = 16'h0000;
        repeat (5) @(posedge clk);
        check_reset_state();
        #1;
        rst_n_i = 1'b1;
        check_geometry();
        check_bus_access();
        check_priority_mode();
        check_alpha_mix();
        check_additive();
        check_scroll();
        $display("TEST OK");
        $finish;
    end

endmodule

//--- hdl/video_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video top
// timing, register slave, two playfields and blender
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  vid_pkg::wb_adr_t wb_adr_i,
    input  vid_pkg::wb_dat_t wb_dat_i,
    output vid_pkg::wb_dat_t wb_dat_o,
    output logic             wb_ack_o,
    output vid_pkg::rgb_t    rgb_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             de_o
);

    vid_pkg::hpos_t    hpos;
    vid_pkg::vpos_t    vpos;
    logic              de;
    logic              hsync;
    logic              vsync;
    logic              pal_we_a;
    logic              pal_we_b;
    vid_pkg::pal_idx_t pal_wr_idx;
    vid_pkg::argb_t    pal_wr_dat;
    logic              blend_en;
    vid_pkg::pal_idx_t scroll_a;
    vid_pkg::pal_idx_t scroll_b;
    vid_pkg::argb_t    color_a;
    vid_pkg::argb_t    color_b;

    video_timing u_timing (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hpos_o  (hpos),
        .vpos_o  (vpos),
        .de_o    (de),
        .hsync_o (hsync),
        .vsync_o (vsync)
    );

    wb_reg_fsm u_regs (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .pal_we_a_o   (pal_we_a),
        .pal_we_b_o   (pal_we_b),
        .pal_wr_idx_o (pal_wr_idx),
        .pal_wr_dat_o (pal_wr_dat),
        .blend_en_o   (blend_en),
        .scroll_a_o   (scroll_a),
        .scroll_b_o   (scroll_b)
    );

    // playfield A indexes along the line
    playfield_lut u_pf_a (
        .clk      (clk),
        .hpos_i   (hpos),
        .vpos_i   (vid_pkg::vpos_t'(0)),
        .scroll_i (scroll_a),
        .we_i     (pal_we_a),
        .wr_idx_i (pal_wr_idx),
        .wr_dat_i (pal_wr_dat),
        .color_o  (color_a)
    );

    // playfield B indexes down the frame
    playfield_lut u_pf_b (
        .clk      (clk),
        .hpos_i   (vid_pkg::hpos_t'(0)),
        .vpos_i   (vpos),
        .scroll_i (scroll_b),
        .we_i     (pal_we_b),
        .wr_idx_i (pal_wr_idx),
        .wr_dat_i (pal_wr_dat),
        .color_o  (color_b)
    );

    video_blend u_blend (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .blend_en_i (blend_en),
        .color_a_i  (color_a),
        .color_b_i  (color_b),
        .de_i       (de),
        .hsync_i    (hsync),
        .vsync_i    (vsync),
        .rgb_o      (rgb_o),
        .de_o       (de_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o)
    );

endmodule

//--- hdl/video_blend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video blend
// mixes playfield A and B colors by their alpha bits
// or picks one by priority, syncs delayed to match
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_blend (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           blend_en_i,
    input  vid_pkg::argb_t color_a_i,
    input  vid_pkg::argb_t color_b_i,
    input  logic           de_i,
    input  logic           hsync_i,
    input  logic           vsync_i,
    output vid_pkg::rgb_t  rgb_o,
    output logic           de_o,
    output logic           hsync_o,
    output logic           vsync_o
);

    logic [1:0]    alpha_a;
    logic [1:0]    alpha_b;
    vid_pkg::rgb_t blend_mix;       // alpha rules applied per channel
    vid_pkg::rgb_t prio_pick;       // plain A over B selection
    vid_pkg::rgb_t pix_d;
    logic          de_1;
    logic          hsync_1;
    logic          vsync_1;

    // one 4-bit channel of the blend
    function automatic logic [3:0] mix_chan(
        input logic [3:0] a,
        input logic [3:0] b,
        input logic [1:0] al_a,
        input logic [1:0] al_b
    );
        logic [5:0] sum_3a_b;       // 3a + b, divided by 4 below
        logic [4:0] sum_a_b;        // a + b with carry
        logic [3:0] res;
        sum_3a_b = {2'b00, a} + {1'b0, a, 1'b0} + {2'b00, b};
        sum_a_b  = {1'b0, a} + {1'b0, b};
        case (al_a)
            2'b00: begin            // B alpha picks the mix
                case (al_b)
                    2'b00:   res = a;               // A only
                    2'b01:   res = sum_3a_b[5:2];   // 3/4 A + 1/4 B
                    2'b10:   res = sum_a_b[4:1];    // half and half
                    default: res = b;               // B only
                endcase
            end
            2'b01:   res = sum_a_b[3:0];            // wraps on overflow
            2'b10:   res = (a[3] & b[3]) ? 4'hF : sum_a_b[3:0];  // saturate when both msbs set
            default: res = a;                       // A on top
        endcase
        return res;
    endfunction

    assign alpha_a = color_a_i[15:14];
    assign alpha_b = color_b_i[15:14];

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            blend_mix[c*4 +: 4] = mix_chan(color_a_i[c*4 +: 4], color_b_i[c*4 +: 4],
                                           alpha_a, alpha_b);
        end
    end

    // B shows through only where A is low priority and B is high
    assign prio_pick = (!alpha_a[1] && alpha_b[1]) ? color_b_i[11:0] : color_a_i[11:0];
    assign pix_d     = blend_en_i ? blend_mix : prio_pick;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rgb_o   <= '0;
            de_1    <= 1'b0;
            hsync_1 <= 1'b0;
            vsync_1 <= 1'b0;
            de_o    <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
        end else begin
            rgb_o   <= de_1 ? pix_d : '0;   // palette data belongs to the de_1 pixel
            de_1    <= de_i;                // first stage covers the palette read
            hsync_1 <= hsync_i;
            vsync_1 <= vsync_i;
            de_o    <= de_1;                // second stage lines up with rgb_o
            hsync_o <= hsync_1;
            vsync_o <= vsync_1;
        end
    end

    // blanking holds color at zero outside the active area
    a_blank_zero : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !de_o |-> (rgb_o == '0)
    ) else $error("rgb_o not zero during blanking");

endmodule

//--- hdl/playfield_lut.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// playfield lookup
// palette index from raster position plus scroll
// and a 16-entry palette RAM with registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module playfield_lut (
    input  logic              clk,
    input  vid_pkg::hpos_t    hpos_i,
    input  vid_pkg::vpos_t    vpos_i,
    input  vid_pkg::pal_idx_t scroll_i,
    input  logic              we_i,
    input  vid_pkg::pal_idx_t wr_idx_i,
    input  vid_pkg::argb_t    wr_dat_i,
    output vid_pkg::argb_t    color_o
);

    vid_pkg::argb_t    pal_mem [vid_pkg::PAL_DEPTH];  // maps to a small block RAM
    vid_pkg::pal_idx_t rd_idx;
    vid_pkg::argb_t    color_q;

    // 4-bit adder wraps, giving the modulo 16 for free
    // the unused axis is tied to zero at the top
    assign rd_idx = vid_pkg::pal_idx_t'(hpos_i) +
                    vid_pkg::pal_idx_t'(vpos_i) +
                    scroll_i;

    // bus side write port
    always_ff @(posedge clk) begin
        if (we_i) begin
            pal_mem[wr_idx_i] <= wr_dat_i;
        end
    end

    // video side read port, one cycle of latency
    always_ff @(posedge clk) begin
        color_q <= pal_mem[rd_idx];
    end

    assign color_o = color_q;

endmodule

//--- hdl/wb_reg_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone register slave
// classic single-cycle-wait slave for palette writes
// and the control register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module wb_reg_fsm (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  vid_pkg::wb_adr_t  wb_adr_i,
    input  vid_pkg::wb_dat_t  wb_dat_i,
    output vid_pkg::wb_dat_t  wb_dat_o,
    output logic              wb_ack_o,
    output logic              pal_we_a_o,
    output logic              pal_we_b_o,
    output vid_pkg::pal_idx_t pal_wr_idx_o,
    output vid_pkg::argb_t    pal_wr_dat_o,
    output logic              blend_en_o,
    output vid_pkg::pal_idx_t scroll_a_o,
    output vid_pkg::pal_idx_t scroll_b_o
);

    vid_pkg::wb_state_e state_q;
    vid_pkg::wb_state_e state_d;
    vid_pkg::wb_dat_t   ctrl_q;         // control register, undefined bits held at zero
    vid_pkg::wb_dat_t   rd_dat;
    logic               bus_req;        // new cycle seen while idle
    logic               hit_pal_a;
    logic               hit_pal_b;
    logic               hit_ctrl;

    assign bus_req   = (state_q == vid_pkg::WB_IDLE) && wb_cyc_i && wb_stb_i;
    assign hit_pal_a = (wb_adr_i & vid_pkg::ADR_WIN_MASK) == vid_pkg::ADR_PAL_A_BASE;
    assign hit_pal_b = (wb_adr_i & vid_pkg::ADR_WIN_MASK) == vid_pkg::ADR_PAL_B_BASE;
    assign hit_ctrl  = (wb_adr_i == vid_pkg::ADR_CTRL);

    // palettes are write only, so only ctrl gives data back
    assign rd_dat = hit_ctrl ? ctrl_q : '0;

    always_comb begin
        state_d = state_q;
        case (state_q)
            vid_pkg::WB_IDLE: begin
                if (wb_cyc_i && wb_stb_i) begin
                    state_d = vid_pkg::WB_ACK;
                end
            end
            vid_pkg::WB_ACK:  state_d = vid_pkg::WB_IDLE;  // ack is a single pulse
            default:          state_d = vid_pkg::WB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= vid_pkg::WB_IDLE;
            pal_we_a_o <= 1'b0;
            pal_we_b_o <= 1'b0;
            ctrl_q     <= '0;
        end else begin
            state_q    <= state_d;
            pal_we_a_o <= bus_req && wb_we_i && hit_pal_a;  // strobe lands on the ack cycle
            pal_we_b_o <= bus_req && wb_we_i && hit_pal_b;
            if (bus_req && wb_we_i && hit_ctrl) begin
                ctrl_q <= wb_dat_i & vid_pkg::CTRL_MASK;
            end
        end
    end

    // write payload and read data captured with the request
    always_ff @(posedge clk) begin
        if (bus_req) begin
            pal_wr_idx_o <= vid_pkg::pal_idx_t'(wb_adr_i);  // low bits index the window
            pal_wr_dat_o <= wb_dat_i;
            wb_dat_o     <= rd_dat;
        end
    end

    assign wb_ack_o   = (state_q == vid_pkg::WB_ACK);
    assign blend_en_o = ctrl_q[vid_pkg::CTRL_BLEND_BIT];
    assign scroll_a_o = ctrl_q[vid_pkg::CTRL_SCROLL_A_LSB +: $bits(vid_pkg::pal_idx_t)];
    assign scroll_b_o = ctrl_q[vid_pkg::CTRL_SCROLL_B_LSB +: $bits(vid_pkg::pal_idx_t)];

    // master holds stb until ack, so the FSM must drop back to idle in between
    a_ack_single : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o
    ) else $error("ack high for two cycles");

endmodule

//--- hdl/video_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video timing
// raster counters with registered sync and display enable
// all outputs describe the same pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_timing (
    input  logic          clk,
    input  logic          rst_n_i,
    output vid_pkg::hpos_t hpos_o,
    output vid_pkg::vpos_t vpos_o,
    output logic          de_o,
    output logic          hsync_o,
    output logic          vsync_o
);

    vid_pkg::hpos_t hpos_q;
    vid_pkg::vpos_t vpos_q;
    vid_pkg::hpos_t hpos_nxt;
    vid_pkg::vpos_t vpos_nxt;
    logic           h_wrap;         // last pixel of the line
    logic           v_wrap;         // last line of the frame
    logic           de_q;
    logic           hsync_q;
    logic           vsync_q;

    assign h_wrap = (hpos_q == vid_pkg::hpos_t'(vid_pkg::H_TOTAL - 1));
    assign v_wrap = (vpos_q == vid_pkg::vpos_t'(vid_pkg::V_TOTAL - 1));

    // next raster position
    always_comb begin
        hpos_nxt = h_wrap ? '0 : hpos_q + 1'b1;
        vpos_nxt = vpos_q;
        if (h_wrap) begin
            vpos_nxt = v_wrap ? '0 : vpos_q + 1'b1;     // step down one line per wrap
        end
    end

    // flags are decoded from the next position so they line up with the counters
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hpos_q  <= '0;
            vpos_q  <= '0;
            de_q    <= 1'b0;
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
        end else begin
            hpos_q  <= hpos_nxt;
            vpos_q  <= vpos_nxt;
            de_q    <= (hpos_nxt < vid_pkg::hpos_t'(vid_pkg::H_ACTIVE)) &&
                       (vpos_nxt < vid_pkg::vpos_t'(vid_pkg::V_ACTIVE));
            hsync_q <= (hpos_nxt >= vid_pkg::hpos_t'(vid_pkg::HS_START)) &&
                       (hpos_nxt <  vid_pkg::hpos_t'(vid_pkg::HS_END));
            // whole line of vsync
            vsync_q <= (vpos_nxt >= vid_pkg::vpos_t'(vid_pkg::VS_START)) &&
                       (vpos_nxt <  vid_pkg::vpos_t'(vid_pkg::VS_END));
        end
    end

    assign hpos_o  = hpos_q;
    assign vpos_o  = vpos_q;
    assign de_o    = de_q;
    assign hsync_o = hsync_q;
    assign vsync_o = vsync_q;

    // wrap logic keeps the pixel counter inside the line
    a_hpos_range : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        hpos_q < vid_pkg::hpos_t'(vid_pkg::H_TOTAL)
    ) else $error("hpos reached H_TOTAL");

endmodule

//--- hdl/vid_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video package
// screen geometry, color and bus widths, register map
// and the bus FSM states shared by the video stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vid_pkg;

    // horizontal geometry in pixels
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 2;
    localparam int H_BACK   = 4;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 24
    localparam int HS_START = H_ACTIVE + H_FRONT;   // first hsync pixel
    localparam int HS_END   = HS_START + H_SYNC;    // first pixel after hsync

    // vertical geometry in lines
    localparam int V_ACTIVE = 8;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 1;
    localparam int V_BACK   = 2;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 12
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    localparam int PAL_DEPTH = 16;              // entries per palette

    typedef logic [15:0] argb_t;                // aa__rrrrggggbbbb
    typedef logic [11:0] rgb_t;
    typedef logic [3:0]  pal_idx_t;
    typedef logic [4:0]  hpos_t;
    typedef logic [3:0]  vpos_t;
    typedef logic [5:0]  wb_adr_t;
    typedef logic [15:0] wb_dat_t;

    // register map
    localparam wb_adr_t ADR_WIN_MASK   = 6'h30;  // selects the 16-word window
    localparam wb_adr_t ADR_PAL_A_BASE = 6'h00;
    localparam wb_adr_t ADR_PAL_B_BASE = 6'h10;
    localparam wb_adr_t ADR_CTRL       = 6'h20;

    // control register fields
    localparam int      CTRL_BLEND_BIT    = 0;
    localparam int      CTRL_SCROLL_A_LSB = 4;   // scroll A in 7:4
    localparam int      CTRL_SCROLL_B_LSB = 8;   // scroll B in 11:8
    localparam wb_dat_t CTRL_MASK         = 16'h0FF1;

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

endpackage
